//--- frame_counters.sv
// Per-port frame and byte statistics
// Counts transferred beats on each stream, cleared per port by mask
`timescale 1ns/1ps

module frame_counters (
    input  logic                                phys_port_clk_ifc,
    input  logic                                rst_n,
    input  logic [pkt_gen_pkg::NUM_PORTS-1:0]   clear_mask,
    stream_if.monitor                           streams [pkt_gen_pkg::NUM_PORTS],
    output logic [pkt_gen_pkg::CNT_W-1:0]       frame_cnt [pkt_gen_pkg::NUM_PORTS],
    output logic [pkt_gen_pkg::CNT_W-1:0]       byte_cnt [pkt_gen_pkg::NUM_PORTS]
);
    import pkt_gen_pkg::*;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic                  beat;
        logic                  frame_end;
        logic [DATA_BYTES-1:0] keep;

        assign beat      = streams[p].tvalid && streams[p].tready;
        assign frame_end = beat && streams[p].tlast;
        assign keep      = streams[p].tkeep;

        // Clear takes priority over a same-cycle beat
        always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
            if (!rst_n) begin
                frame_cnt[p] <= '0;
                byte_cnt[p]  <= '0;
            end else if (clear_mask[p]) begin
                frame_cnt[p] <= '0;
                byte_cnt[p]  <= '0;
            end else if (beat) begin
                byte_cnt[p] <= byte_cnt[p] + CNT_W'($countones(keep));
                if (frame_end) begin
                    frame_cnt[p] <= frame_cnt[p] + CNT_W'(1);
                end
            end
        end
    end

endmodule

//--- pkt_gen_pkg.sv
// Packet generator shared definitions
// Widths, limits, register map and state/payload encodings
package pkt_gen_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream and port sizing

    localparam int DATA_BYTES = 4;
    localparam int DATA_W     = 32;
    localparam int NUM_PORTS  = 2;

    // Packet length limits in bytes
    localparam int MTU_BYTES  = 1500;
    localparam int MIN_BLEN   = 64;
    localparam int BLEN_W     = 11;

    localparam int CNT_W      = 32;
    localparam int REG_DATA_W = 32;
    localparam int REG_ADDR_W = 4;

    localparam logic [DATA_W-1:0] LFSR_SEED = 32'hACE1_2468;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings

    typedef enum logic {
        GEN_IDLE = 1'b0,
        GEN_SEND = 1'b1
    } gen_state_e;

    typedef enum logic {
        PAYLOAD_INC  = 1'b0,
        PAYLOAD_LFSR = 1'b1
    } payload_e;

    // Bit i of enable/payload/clear belongs to port i
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_ENABLE    = 4'd0,
        REG_PAYLOAD   = 4'd1,
        REG_CLEAR     = 4'd2,
        REG_FRAMES_P0 = 4'd4,
        REG_FRAMES_P1 = 4'd5,
        REG_BYTES_P0  = 4'd6,
        REG_BYTES_P1  = 4'd7
    } reg_addr_e;

endpackage

//--- pkt_gen_port.sv
// Single port packet generator
// Streams one packet per request with incrementing or LFSR payload
`timescale 1ns/1ps

module pkt_gen_port (
    input  logic                             phys_port_clk_ifc,
    input  logic                             rst_n,
    input  logic                             enable,
    input  pkt_gen_pkg::payload_e            payload_sel,
    input  logic                             send_req,
    input  logic [pkt_gen_pkg::BLEN_W-1:0]   send_blen,
    output logic                             busy,
    stream_if.source                         stream
);
    import pkt_gen_pkg::*;

    gen_state_e            state;
    payload_e              payload_q;
    logic [BLEN_W-1:0]     bytes_left;
    logic [7:0]            byte_base;
    logic [DATA_W-1:0]     lfsr;
    logic [DATA_W-1:0]     raw_word;
    logic [DATA_BYTES-1:0] keep;
    logic                  last_word;
    logic                  start;
    logic                  beat;
    logic                  lfsr_fb;

    assign start   = (state == GEN_IDLE) && enable && send_req;
    assign beat    = (state == GEN_SEND) && stream.tready;
    assign lfsr_fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    ////////////////////////////////////////////////////////////////////////////
    // Control

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state      <= GEN_IDLE;
            payload_q  <= PAYLOAD_INC;
            bytes_left <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (start) begin
                        state      <= GEN_SEND;
                        payload_q  <= payload_sel;
                        bytes_left <= send_blen;
                    end
                end
                GEN_SEND: begin
                    if (beat) begin
                        if (last_word) begin
                            state      <= GEN_IDLE;
                            bytes_left <= '0;
                        end else begin
                            bytes_left <= bytes_left - BLEN_W'(DATA_BYTES);
                        end
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload sources, advance only on an accepted beat

    always_ff @(posedge phys_port_clk_ifc) begin
        if (start) begin
            byte_base <= 8'h00;
            lfsr      <= LFSR_SEED;
        end else if (beat) begin
            byte_base <= byte_base + 8'(DATA_BYTES);
            lfsr      <= {lfsr[DATA_W-2:0], lfsr_fb};
        end
    end

    // Lane i is live while more than i bytes remain
    always_comb begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            keep[i] = (bytes_left > BLEN_W'(i));
        end
    end

    always_comb begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (payload_q == PAYLOAD_LFSR) begin
                raw_word[8*i +: 8] = lfsr[8*i +: 8];
            end else begin
                raw_word[8*i +: 8] = byte_base + 8'(i);
            end
        end
    end

    assign last_word = (bytes_left <= BLEN_W'(DATA_BYTES));

    always_comb begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            stream.tdata[8*i +: 8] = keep[i] ? raw_word[8*i +: 8] : 8'h00;
        end
    end

    assign stream.tkeep  = keep;
    assign stream.tvalid = (state == GEN_SEND);
    assign stream.tlast  = (state == GEN_SEND) && last_word;
    assign busy          = (state == GEN_SEND);

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Stalled beat keeps its contents until taken
    assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        stream.tvalid && !stream.tready |=> stream.tvalid && $stable(stream.tdata)
            && $stable(stream.tkeep) && $stable(stream.tlast))
        else $error("stream changed while stalled");

    assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        $rose(busy) |-> bytes_left >= BLEN_W'(MIN_BLEN) && bytes_left <= BLEN_W'(MTU_BYTES))
        else $error("packet length out of range: %0d", bytes_left);

endmodule

//--- pkt_gen_regs.sv
// Register block for port control and counter readback
// Plain read/write strobes, read data returned one cycle later
`timescale 1ns/1ps

module pkt_gen_regs (
    input  logic                                 phys_port_clk_ifc,
    input  logic                                 rst_n,
    input  logic                                 reg_write,
    input  logic                                 reg_read,
    input  logic [pkt_gen_pkg::REG_ADDR_W-1:0]   reg_addr,
    input  logic [pkt_gen_pkg::REG_DATA_W-1:0]   reg_wdata,
    output logic [pkt_gen_pkg::REG_DATA_W-1:0]   reg_rdata,
    output logic                                 reg_rvalid,
    output logic [pkt_gen_pkg::NUM_PORTS-1:0]    port_enable,
    output pkt_gen_pkg::payload_e                payload_sel [pkt_gen_pkg::NUM_PORTS],
    output logic [pkt_gen_pkg::NUM_PORTS-1:0]    clear_mask,
    input  logic [pkt_gen_pkg::CNT_W-1:0]        frame_cnt [pkt_gen_pkg::NUM_PORTS],
    input  logic [pkt_gen_pkg::CNT_W-1:0]        byte_cnt [pkt_gen_pkg::NUM_PORTS]
);
    import pkt_gen_pkg::*;

    logic [REG_DATA_W-1:0] rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    always_ff @(posedge phys_port_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            port_enable <= '0;
            payload_sel <= '{default: PAYLOAD_INC};
            clear_mask  <= '0;
            reg_rvalid  <= 1'b0;
        end else begin
            // Clear is a single cycle pulse
            clear_mask <= '0;
            reg_rvalid <= reg_read;
            if (reg_write) begin
                case (reg_addr)
                    REG_ENABLE: begin
                        port_enable <= reg_wdata[NUM_PORTS-1:0];
                    end
                    REG_PAYLOAD: begin
                        for (int p = 0; p < NUM_PORTS; p++) begin
                            payload_sel[p] <= payload_e'(reg_wdata[p]);
                        end
                    end
                    REG_CLEAR: begin
                        clear_mask <= reg_wdata[NUM_PORTS-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side

    always_comb begin
        rd_data = '0;
        case (reg_addr)
            REG_ENABLE: begin
                rd_data[NUM_PORTS-1:0] = port_enable;
            end
            REG_PAYLOAD: begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    rd_data[p] = payload_sel[p];
                end
            end
            REG_FRAMES_P0: rd_data = frame_cnt[0];
            REG_FRAMES_P1: rd_data = frame_cnt[1];
            REG_BYTES_P0:  rd_data = byte_cnt[0];
            REG_BYTES_P1:  rd_data = byte_cnt[1];
            // Clear and unmapped addresses read as zero
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (reg_read) begin
            reg_rdata <= rd_data;
        end
    end

    assert property (@(posedge phys_port_clk_ifc) disable iff (!rst_n)
        !(reg_read && reg_write))
        else $error("register read and write in the same cycle");

endmodule

//--- pkt_gen_top.f
pkt_gen_pkg.sv
stream_if.sv
pkt_gen_port.sv
frame_counters.sv
pkt_gen_regs.sv
pkt_gen_top.sv
tb_pkt_gen_top.sv

//--- pkt_gen_top.sv
// Two-port stream packet generator with frame and byte statistics
`timescale 1ns/1ps

module pkt_gen_top (
    input  logic                                  phys_port_clk_ifc,
    input  logic                                  rst_n,
    input  logic [pkt_gen_pkg::NUM_PORTS-1:0]     send_req,
    input  logic [pkt_gen_pkg::BLEN_W-1:0]        send_blen [pkt_gen_pkg::NUM_PORTS],
    output logic [pkt_gen_pkg::NUM_PORTS-1:0]     busy,
    output logic [pkt_gen_pkg::DATA_W-1:0]        tdata [pkt_gen_pkg::NUM_PORTS],
    output logic [pkt_gen_pkg::DATA_BYTES-1:0]    tkeep [pkt_gen_pkg::NUM_PORTS],
    output logic [pkt_gen_pkg::NUM_PORTS-1:0]     tvalid,
    output logic [pkt_gen_pkg::NUM_PORTS-1:0]     tlast,
    input  logic [pkt_gen_pkg::NUM_PORTS-1:0]     tready,
    input  logic                                  reg_write,
    input  logic                                  reg_read,
    input  logic [pkt_gen_pkg::REG_ADDR_W-1:0]    reg_addr,
    input  logic [pkt_gen_pkg::REG_DATA_W-1:0]    reg_wdata,
    output logic [pkt_gen_pkg::REG_DATA_W-1:0]    reg_rdata,
    output logic                                  reg_rvalid
);
    import pkt_gen_pkg::*;

    logic [NUM_PORTS-1:0] port_enable;
    payload_e             payload_sel [NUM_PORTS];
    logic [NUM_PORTS-1:0] clear_mask;
    logic [CNT_W-1:0]     frame_cnt [NUM_PORTS];
    logic [CNT_W-1:0]     byte_cnt [NUM_PORTS];

    stream_if stream [NUM_PORTS] ();

    ////////////////////////////////////////////////////////////////////////////
    // Generators

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        pkt_gen_port port_i (
            .phys_port_clk_ifc (phys_port_clk_ifc),
            .rst_n             (rst_n),
            .enable            (port_enable[p]),
            .payload_sel       (payload_sel[p]),
            .send_req          (send_req[p]),
            .send_blen         (send_blen[p]),
            .busy              (busy[p]),
            .stream            (stream[p])
        );

        // Stream out to the pins, back-pressure in
        assign tdata[p]         = stream[p].tdata;
        assign tkeep[p]         = stream[p].tkeep;
        assign tvalid[p]        = stream[p].tvalid;
        assign tlast[p]         = stream[p].tlast;
        assign stream[p].tready = tready[p];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Statistics and control

    frame_counters counters_i (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .clear_mask        (clear_mask),
        .streams           (stream),
        .frame_cnt         (frame_cnt),
        .byte_cnt          (byte_cnt)
    );

    pkt_gen_regs regs_i (
        .phys_port_clk_ifc (phys_port_clk_ifc),
        .rst_n             (rst_n),
        .reg_write         (reg_write),
        .reg_read          (reg_read),
        .reg_addr          (reg_addr),
        .reg_wdata         (reg_wdata),
        .reg_rdata         (reg_rdata),
        .reg_rvalid        (reg_rvalid),
        .port_enable       (port_enable),
        .payload_sel       (payload_sel),
        .clear_mask        (clear_mask),
        .frame_cnt         (frame_cnt),
        .byte_cnt          (byte_cnt)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the packet generator testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pkt_gen_top \
    -f pkt_gen_top.f > build.log 2>&1 || { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/Vtb_pkt_gen_top > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation completed"

//--- stream_if.sv
// Word stream with keep and last, one per generator port
`timescale 1ns/1ps

interface stream_if ();
    import pkt_gen_pkg::*;

    logic [DATA_W-1:0]     tdata;
    logic [DATA_BYTES-1:0] tkeep;
    logic                  tvalid;
    logic                  tlast;
    logic                  tready;

    // Generator side
    modport source (
        output tdata, tkeep, tvalid, tlast,
        input  tready
    );

    // Statistics side, observes only
    modport monitor (
        input tdata, tkeep, tvalid, tlast, tready
    );

endinterface

//--- tb_pkt_gen_top.sv
// Testbench for the two-port packet generator
// LFSR driven lengths and back-pressure, checked against a packet model
`timescale 1ns/1ps

module tb_pkt_gen_top;
    import pkt_gen_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int PKTS       = 6;
    // Three traffic phases on two ports, worst case four cycles per word
    localparam int WATCHDOG_CYCLES = 3 * NUM_PORTS * PKTS * (MTU_BYTES / 4) * 4 + 2000;

    logic                  phys_port_clk_ifc;
    logic                  rst_n;
    logic [NUM_PORTS-1:0]  send_req;
    logic [BLEN_W-1:0]     send_blen [NUM_PORTS];
    logic [NUM_PORTS-1:0]  busy;
    logic [DATA_W-1:0]     tdata [NUM_PORTS];
    logic [DATA_BYTES-1:0] tkeep [NUM_PORTS];
    logic [NUM_PORTS-1:0]  tvalid;
    logic [NUM_PORTS-1:0]  tlast;
    logic [NUM_PORTS-1:0]  tready;
    logic                  reg_write;
    logic                  reg_read;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_DATA_W-1:0] reg_wdata;
    logic [REG_DATA_W-1:0] reg_rdata;
    logic                  reg_rvalid;

    logic [15:0]          rng;

    // Model state per port
    logic [NUM_PORTS-1:0] en_model;
    payload_e             pay_model [NUM_PORTS];
    payload_e             exp_mode [NUM_PORTS];
    logic [DATA_W-1:0]    exp_lfsr [NUM_PORTS];
    int                   exp_len [NUM_PORTS];
    int                   exp_idx [NUM_PORTS];
    int                   exp_frames [NUM_PORTS];
    int                   exp_bytes [NUM_PORTS];
    int                   pkts_left [NUM_PORTS];
    int                   gap [NUM_PORTS];
    int                   hold [NUM_PORTS];
    bit                   in_pkt [NUM_PORTS];
    bit                   req_on [NUM_PORTS];

    pkt_gen_top dut_i (.*);

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: packets did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [15:0] rng_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            rng = rng_step(rng);
            val = (val << 1) | int'(rng[0]);
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Byte k of the packet sits in lane k mod 4
    task automatic build_word(input int p, output logic [DATA_W-1:0] data,
                              output logic [DATA_BYTES-1:0] keep, output logic last);
        int k;
        for (int i = 0; i < DATA_BYTES; i++) begin
            k = exp_idx[p] + i;
            keep[i] = (k < exp_len[p]);
            if (!keep[i])
                data[8*i +: 8] = 8'h00;
            else if (exp_mode[p] == PAYLOAD_LFSR)
                data[8*i +: 8] = exp_lfsr[p][8*i +: 8];
            else
                data[8*i +: 8] = 8'(k % 256);
        end
        last = (exp_idx[p] + DATA_BYTES >= exp_len[p]);
    endtask

    task automatic port_cycle(input int p);
        logic [DATA_W-1:0]     data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        int                    r;
        string                 sfx;
        sfx = $sformatf("[%0d]", p);
        if (!in_pkt[p]) begin
            if (req_on[p] && en_model[p]) begin
                // Request taken at the last edge, first word valid now
                check({"busy", sfx}, 32'(busy[p]), 1);
                in_pkt[p]   = 1'b1;
                req_on[p]   = 1'b0;
                send_req[p] = 1'b0;
                exp_idx[p]  = 0;
                exp_lfsr[p] = LFSR_SEED;
                exp_mode[p] = pay_model[p];
            end else begin
                check({"busy", sfx}, 32'(busy[p]), 0);
                check({"tvalid", sfx}, 32'(tvalid[p]), 0);
                if (req_on[p]) begin
                    hold[p]--;
                    if (hold[p] == 0) begin
                        req_on[p]   = 1'b0;
                        send_req[p] = 1'b0;
                        draw(2, r);
                        gap[p] = 1 + r;
                    end
                end
            end
        end
        // About a quarter of cycles stalled, applies at the coming edge
        draw(2, r);
        tready[p] = (r != 0);
        if (in_pkt[p]) begin
            check({"busy", sfx}, 32'(busy[p]), 1);
            check({"tvalid", sfx}, 32'(tvalid[p]), 1);
            if (tready[p]) begin
                build_word(p, data, keep, last);
                check({"tdata", sfx}, tdata[p], data);
                check({"tkeep", sfx}, 32'(tkeep[p]), 32'(keep));
                check({"tlast", sfx}, 32'(tlast[p]), 32'(last));
                exp_bytes[p] += $countones(keep);
                exp_idx[p]   += DATA_BYTES;
                exp_lfsr[p]   = {exp_lfsr[p][30:0],
                                 exp_lfsr[p][31] ^ exp_lfsr[p][21] ^ exp_lfsr[p][1] ^ exp_lfsr[p][0]};
                if (last) begin
                    in_pkt[p] = 1'b0;
                    exp_frames[p]++;
                    draw(2, r);
                    gap[p] = 1 + r;
                end
            end
        end
        if (!in_pkt[p] && !req_on[p] && pkts_left[p] > 0) begin
            if (gap[p] > 0) begin
                gap[p]--;
            end else begin
                draw(BLEN_W, r);
                exp_len[p]   = MIN_BLEN + r % (MTU_BYTES - MIN_BLEN + 1);
                send_blen[p] = BLEN_W'(exp_len[p]);
                send_req[p]  = 1'b1;
                req_on[p]    = 1'b1;
                hold[p]      = 8;
                pkts_left[p]--;
            end
        end
    endtask

    task automatic tick();
        @(negedge phys_port_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_cycle(p);
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [REG_DATA_W-1:0] data);
        tick();
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        tick();
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] exp, input string name);
        tick();
        check("reg_rvalid", 32'(reg_rvalid), 0);
        reg_read = 1'b1;
        reg_addr = addr;
        tick();
        reg_read = 1'b0;
        check("reg_rvalid", 32'(reg_rvalid), 1);
        check(name, reg_rdata, exp);
    endtask

    task automatic check_counters();
        read_reg(REG_FRAMES_P0, exp_frames[0], "frames_p0");
        read_reg(REG_FRAMES_P1, exp_frames[1], "frames_p1");
        read_reg(REG_BYTES_P0, exp_bytes[0], "bytes_p0");
        read_reg(REG_BYTES_P1, exp_bytes[1], "bytes_p1");
    endtask

    task automatic run_traffic(input int n0, input int n1);
        pkts_left[0] = n0;
        pkts_left[1] = n1;
        while (pkts_left[0] > 0 || pkts_left[1] > 0 || in_pkt[0] || in_pkt[1]
               || req_on[0] || req_on[1]) begin
            tick();
        end
        // Ports idle once the last tlast has gone
        tick();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        rng       = 16'd46;
        rst_n     = 1'b0;
        send_req  = '0;
        send_blen = '{default: '0};
        tready    = '0;
        reg_write = 1'b0;
        reg_read  = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        en_model  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            pay_model[p]  = PAYLOAD_INC;
            exp_frames[p] = 0;
            exp_bytes[p]  = 0;
            pkts_left[p]  = 0;
            gap[p]        = 0;
            in_pkt[p]     = 1'b0;
            req_on[p]     = 1'b0;
        end
        repeat (5) @(posedge phys_port_clk_ifc);
        @(negedge phys_port_clk_ifc);
        rst_n = 1'b1;

        check("busy", 32'(busy), 0);
        check("tvalid", 32'(tvalid), 0);
        check("reg_rvalid", 32'(reg_rvalid), 0);
        read_reg(REG_ENABLE, 0, "enable");
        read_reg(REG_PAYLOAD, 0, "payload");
        check_counters();

        // Both ports on, incrementing payload
        write_reg(REG_ENABLE, 32'h3);
        en_model = 2'b11;
        run_traffic(PKTS, PKTS);
        check_counters();

        // Port 1 on LFSR payload
        write_reg(REG_PAYLOAD, 32'h2);
        pay_model[1] = PAYLOAD_LFSR;
        read_reg(REG_PAYLOAD, 32'h2, "payload");
        run_traffic(PKTS, PKTS);

        // Port 1 off, its requests go nowhere
        write_reg(REG_ENABLE, 32'h1);
        en_model = 2'b01;
        run_traffic(PKTS, 3);
        read_reg(REG_ENABLE, 32'h1, "enable");
        check_counters();

        write_reg(REG_CLEAR, 32'h1);
        exp_frames[0] = 0;
        exp_bytes[0]  = 0;
        read_reg(REG_CLEAR, 0, "clear");
        read_reg(4'hF, 0, "unmapped");
        check_counters();

        $display("Testbench passed");
        $finish;
    end

endmodule
